// File: logic/gb_bus_pkg.sv
`default_nettype none

package gb_bus_pkg;

  //////////////////////////////////////////////////
  // Bus and bank widths
  //////////////////////////////////////////////////
  localparam int GB_ADDR_W    = 16; // CPU address bus
  localparam int GB_DATA_W    = 8;  // CPU data bus
  localparam int ROM_BANK_W   = 9;  // MBC5 ROM bank register
  localparam int RAM_BANK_W   = 4;  // MBC5 RAM bank register
  localparam int FLASH_OFFS_W = 13; // Word offset inside one 16 KiB bank
  localparam int FLASH_DATA_W = 16; // Flash strapped for x16 mode

  // Bank number sits on top of the word offset
  localparam int FLASH_ADDR_W = ROM_BANK_W + FLASH_OFFS_W;

  //////////////////////////////////////////////////
  // Plain vector types
  //////////////////////////////////////////////////
  typedef logic [GB_ADDR_W-1:0]    gb_addr_t;
  typedef logic [GB_DATA_W-1:0]    gb_data_t;
  typedef logic [ROM_BANK_W-1:0]   rom_bank_t;
  typedef logic [RAM_BANK_W-1:0]   ram_bank_t;
  typedef logic [FLASH_ADDR_W-1:0] flash_addr_t; // 16-bit word address
  typedef logic [FLASH_DATA_W-1:0] flash_word_t;

  //////////////////////////////////////////////////
  // Cartridge access, one per cycle
  //////////////////////////////////////////////////
  typedef struct packed {
    gb_addr_t addr;  // Byte address from the CPU
    gb_data_t wdata; // Only meaningful with wr
    logic     wr;    // Write strobe
    logic     rd;    // Read strobe
  } gb_bus_req_t;

endpackage

`default_nettype wire

// File: logic/gb_debug_pkg.sv
`default_nettype none

package gb_debug_pkg;

  //////////////////////////////////////////////////
  // Breakpoint FSM
  //////////////////////////////////////////////////
  typedef enum logic [1:0] {
    RUN    = 2'd0, // Free running, compare every fetch
    HALTED = 2'd1, // CPU held
    STEP   = 2'd2, // One fetch allowed, then back to HALTED
    RESUME = 2'd3  // One fetch allowed without compare, then RUN
  } bp_state_t;

  // Instruction fetch seen on the CPU side
  typedef struct packed {
    gb_bus_pkg::gb_addr_t pc;
    logic                 valid;
  } pc_fetch_t;

  // Status word for the debugger display
  typedef struct packed {
    gb_bus_pkg::gb_addr_t  bp_addr;
    bp_state_t             state;
    gb_bus_pkg::rom_bank_t rom_bank;
    gb_bus_pkg::ram_bank_t ram_bank;
    logic                  ram_enable;
  } dbg_status_t;

endpackage

`default_nettype wire

// File: logic/button_conditioner.sv
`timescale 1ns/100ps
`default_nettype none

module button_conditioner #(
  parameter int DEBOUNCE_CYCLES = 16
) (
  input  wire  bp_change,
  input  wire  reset,
  input  wire  button_in,  // Raw level straight off the pad
  output logic debounced,  // Clean level, also drives the LED
  output logic pressed     // One cycle on each press
);

  localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

  logic [1:0]       sync_q;   // Two-flop synchronizer
  logic [CNT_W-1:0] stable_cnt;
  logic             pending;  // Synced level differs from debounced
  logic             expired;

  //////////////////////////////////////////////////
  // Synchronizer
  //////////////////////////////////////////////////
  always_ff @(posedge bp_change or posedge reset) begin
    if (reset) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[0], button_in};
    end
  end

  assign pending = sync_q[1] ^ debounced;
  assign expired = (stable_cnt == CNT_W'(DEBOUNCE_CYCLES));

  //////////////////////////////////////////////////
  // Stability counter and debounced level
  //////////////////////////////////////////////////
  always_ff @(posedge bp_change or posedge reset) begin
    if (reset) begin
      stable_cnt <= '0;
      debounced  <= 1'b0;
      pressed    <= 1'b0;
    end else begin
      pressed <= 1'b0;
      if (!pending) begin
        stable_cnt <= '0;                 // Bounce back or idle, start over
      end else if (expired) begin
        stable_cnt <= '0;
        debounced  <= sync_q[1];          // Held long enough, follow it
        pressed    <= sync_q[1];          // Rising edge only
      end else begin
        stable_cnt <= stable_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/mbc5_banking.sv
`timescale 1ns/100ps
`default_nettype none

module mbc5_banking (
  input  wire                       bp_change,
  input  wire                       reset,
  input  gb_bus_pkg::gb_bus_req_t   bus_req,
  output gb_bus_pkg::rom_bank_t     rom_bank,
  output gb_bus_pkg::ram_bank_t     ram_bank,
  output logic                      ram_enable
);

  import gb_bus_pkg::*;

  logic [3:0] region;        // Upper address nibble
  logic       sel_ram_en;    // 0000-1FFF
  logic       sel_rom_lo;    // 2000-2FFF
  logic       sel_rom_hi;    // 3000-3FFF
  logic       sel_ram_bank;  // 4000-5FFF
  logic       enable_key;    // 0x?A unlocks cart RAM

  assign region     = bus_req.addr[15:12];
  assign enable_key = (bus_req.wdata[3:0] == 4'hA);

  //////////////////////////////////////////////////
  // Register decode
  //////////////////////////////////////////////////
  always_comb begin
    sel_ram_en   = 1'b0;
    sel_rom_lo   = 1'b0;
    sel_rom_hi   = 1'b0;
    sel_ram_bank = 1'b0;
    if (bus_req.wr) begin
      case (region)
        4'h0, 4'h1: sel_ram_en   = 1'b1;
        4'h2:       sel_rom_lo   = 1'b1;
        4'h3:       sel_rom_hi   = 1'b1;
        4'h4, 4'h5: sel_ram_bank = 1'b1;
        default:    ;                      // 6000 and up, no register here
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Bank registers
  //////////////////////////////////////////////////
  always_ff @(posedge bp_change or posedge reset) begin
    if (reset) begin
      rom_bank   <= rom_bank_t'(1);        // MBC5 powers up on bank 1
      ram_bank   <= '0;
      ram_enable <= 1'b0;
    end else begin
      if (sel_ram_en) begin
        ram_enable <= enable_key;          // Anything else locks it
      end

      // Bank 0 is legal on MBC5, no remap to 1
      if (sel_rom_lo) begin
        rom_bank[7:0] <= bus_req.wdata;
      end
      if (sel_rom_hi) begin
        rom_bank[8] <= bus_req.wdata[0];   // Ninth bank bit
      end

      if (sel_ram_bank) begin
        ram_bank <= bus_req.wdata[3:0];
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/cart_flash_port.sv
`timescale 1ns/100ps
`default_nettype none

module cart_flash_port (
  input  wire                       bp_change,
  input  wire                       reset,
  input  gb_bus_pkg::gb_bus_req_t   bus_req,
  input  gb_bus_pkg::rom_bank_t     rom_bank,
  input  gb_bus_pkg::flash_word_t   flash_d,
  output gb_bus_pkg::flash_addr_t   flash_a,
  output logic                      flash_adv_b,
  output gb_bus_pkg::gb_data_t      rd_data,
  output logic                      rd_valid
);

  import gb_bus_pkg::*;

  rom_bank_t                 bank_field;
  logic [FLASH_OFFS_W-1:0]   word_offs;
  gb_data_t                  lane_byte;

  // 0000-3FFF always maps to bank 0, 4000-7FFF to the switchable bank
  assign bank_field = bus_req.addr[14] ? rom_bank : '0;
  assign word_offs  = bus_req.addr[13:1];   // Byte address to x16 word
  assign flash_a    = {bank_field, word_offs};

  assign flash_adv_b = ~bus_req.rd;         // Latch address while reading

  // Odd byte on the upper lane
  assign lane_byte = bus_req.addr[0] ? flash_d[15:8] : flash_d[7:0];

  //////////////////////////////////////////////////
  // Read return
  //////////////////////////////////////////////////
  always_ff @(posedge bp_change) begin
    if (bus_req.rd) begin
      rd_data <= lane_byte;
    end
  end

  always_ff @(posedge bp_change or posedge reset) begin
    if (reset) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= bus_req.rd;               // Data lands one cycle after rd
    end
  end

endmodule

`default_nettype wire

// File: logic/breakpoint_control.sv
`timescale 1ns/100ps
`default_nettype none

module breakpoint_control (
  input  wire                       bp_change,
  input  wire                       reset,
  input  wire [7:0]                 dip_sw,    // Board wires these MSB first
  input  wire                       load,      // One-cycle pulses from buttons
  input  wire                       step,
  input  wire                       cont,
  input  gb_debug_pkg::pc_fetch_t   pc_fetch,
  output gb_bus_pkg::gb_addr_t      bp_addr,
  output gb_debug_pkg::bp_state_t   state,
  output logic                      cpu_halt
);

  import gb_bus_pkg::*;
  import gb_debug_pkg::*;

  gb_data_t  dip_rev;     // Switches in bus bit order
  logic      load_hi;     // Next load goes to the high byte
  logic      bp_hit;
  bp_state_t next_state;

  //////////////////////////////////////////////////
  // Breakpoint address loading
  //////////////////////////////////////////////////
  always_comb begin
    for (int i = 0; i < 8; i++) begin
      dip_rev[i] = dip_sw[7 - i];            // Switch 0 is the MSB
    end
  end

  always_ff @(posedge bp_change or posedge reset) begin
    if (reset) begin
      bp_addr <= '0;
      load_hi <= 1'b0;                       // Start on the low byte
    end else if (load) begin
      if (load_hi) begin
        bp_addr[15:8] <= dip_rev;
      end else begin
        bp_addr[7:0] <= dip_rev;
      end
      load_hi <= ~load_hi;                   // Alternate low, high, low
    end
  end

  //////////////////////////////////////////////////
  // Halt, step and continue FSM
  //////////////////////////////////////////////////
  assign bp_hit = pc_fetch.valid && (pc_fetch.pc == bp_addr);

  always_comb begin
    next_state = state;
    case (state)
      RUN: begin
        if (bp_hit) begin
          next_state = HALTED;               // Stop before this opcode runs
        end
      end
      HALTED: begin
        // Fetches while halted are dropped
        if (cont) begin
          next_state = RESUME;               // Continue beats step
        end else if (step) begin
          next_state = STEP;
        end
      end
      STEP: begin
        if (pc_fetch.valid) begin
          next_state = HALTED;               // Exactly one instruction
        end
      end
      RESUME: begin
        // Skip the compare once, else the breakpoint fires again at once
        if (pc_fetch.valid) begin
          next_state = RUN;
        end
      end
      default: next_state = RUN;
    endcase
  end

  always_ff @(posedge bp_change or posedge reset) begin
    if (reset) begin
      state <= RUN;
    end else begin
      state <= next_state;
    end
  end

  // High from the cycle after the matching fetch
  assign cpu_halt = (state == HALTED);

endmodule

`default_nettype wire

// File: logic/gb_debug_top.sv
`timescale 1ns/100ps
`default_nettype none

module gb_debug_top #(
  parameter int DEBOUNCE_CYCLES = 50000   // About 12 ms at the CPU clock
) (
  input  wire                         bp_change,
  input  wire                         reset,
  input  gb_bus_pkg::gb_bus_req_t     bus_req,      // CPU cartridge access
  input  gb_debug_pkg::pc_fetch_t     pc_fetch,
  input  wire                         btn_step,     // Raw push buttons
  input  wire                         btn_load,
  input  wire                         btn_continue,
  input  wire [7:0]                   dip_sw,
  input  gb_bus_pkg::flash_word_t     flash_d,
  output gb_bus_pkg::flash_addr_t     flash_a,
  output logic                        flash_adv_b,
  output gb_bus_pkg::gb_data_t        rd_data,
  output logic                        rd_valid,
  output logic                        cpu_halt,
  output gb_debug_pkg::dbg_status_t   dbg,
  output logic [2:0]                  btn_leds      // Step, load, continue
);

  import gb_bus_pkg::*;
  import gb_debug_pkg::*;

  logic      step_pulse;
  logic      load_pulse;
  logic      cont_pulse;
  rom_bank_t rom_bank;
  ram_bank_t ram_bank;
  logic      ram_enable;
  gb_addr_t  bp_addr;
  bp_state_t bp_state;

  //////////////////////////////////////////////////
  // Buttons
  //////////////////////////////////////////////////
  button_conditioner #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_btn_step (
    .bp_change (bp_change),
    .reset     (reset),
    .button_in (btn_step),
    .debounced (btn_leds[0]),
    .pressed   (step_pulse)
  );

  button_conditioner #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_btn_load (
    .bp_change (bp_change),
    .reset     (reset),
    .button_in (btn_load),
    .debounced (btn_leds[1]),
    .pressed   (load_pulse)
  );

  button_conditioner #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_btn_continue (
    .bp_change (bp_change),
    .reset     (reset),
    .button_in (btn_continue),
    .debounced (btn_leds[2]),
    .pressed   (cont_pulse)
  );

  //////////////////////////////////////////////////
  // Cartridge side
  //////////////////////////////////////////////////
  mbc5_banking u_mbc5 (
    .bp_change  (bp_change),
    .reset      (reset),
    .bus_req    (bus_req),
    .rom_bank   (rom_bank),
    .ram_bank   (ram_bank),
    .ram_enable (ram_enable)
  );

  cart_flash_port u_flash (
    .bp_change   (bp_change),
    .reset       (reset),
    .bus_req     (bus_req),
    .rom_bank    (rom_bank),
    .flash_d     (flash_d),
    .flash_a     (flash_a),
    .flash_adv_b (flash_adv_b),
    .rd_data     (rd_data),
    .rd_valid    (rd_valid)
  );

  //////////////////////////////////////////////////
  // Debug control
  //////////////////////////////////////////////////
  breakpoint_control u_bp (
    .bp_change (bp_change),
    .reset     (reset),
    .dip_sw    (dip_sw),
    .load      (load_pulse),
    .step      (step_pulse),
    .cont      (cont_pulse),
    .pc_fetch  (pc_fetch),
    .bp_addr   (bp_addr),
    .state     (bp_state),
    .cpu_halt  (cpu_halt)
  );

  // Status word for the debugger screen
  assign dbg.bp_addr    = bp_addr;
  assign dbg.state      = bp_state;
  assign dbg.rom_bank   = rom_bank;
  assign dbg.ram_bank   = ram_bank;
  assign dbg.ram_enable = ram_enable;

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 10
) (
  output logic bp_change,
  output logic reset
);

  // Free running clock
  initial begin
    bp_change = 1'b0;
    forever #(PERIOD_NS / 2) bp_change = ~bp_change;
  end

  // Reset held for a fixed number of edges, then released on an edge
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge bp_change);
    reset <= 1'b0;
  end

endmodule

`default_nettype wire

// File: testbench/gb_debug_tb.sv
`timescale 1ns/100ps
`default_nettype none

module gb_debug_tb;

  import gb_bus_pkg::*;
  import gb_debug_pkg::*;

  localparam int    DEBOUNCE_CYCLES = 4;
  localparam int    CLK_PERIOD_NS   = 8;
  localparam int    CYCLES_PER_TEST = 60;    // Watchdog budget
  localparam int    RELEASE_CYCLES  = 20;
  localparam string TESTS_FILE      = "testbench/gb_debug_tests.txt";

  logic        bp_change;
  logic        reset;
  gb_bus_req_t bus_req;
  pc_fetch_t   pc_fetch;
  logic        btn_step;
  logic        btn_load;
  logic        btn_continue;
  logic [7:0]  dip_sw;
  flash_word_t flash_d;
  flash_addr_t flash_a;
  logic        flash_adv_b;
  gb_data_t    rd_data;
  logic        rd_valid;
  logic        cpu_halt;
  dbg_status_t dbg;
  logic [2:0]  btn_leds;

  // Reference model of the debug state
  rom_bank_t m_rom;
  ram_bank_t m_ram;
  logic      m_ram_en;
  gb_addr_t  m_bp;
  logic      m_load_hi;   // Next load goes high
  bp_state_t m_state;

  // Test table from the file
  string       t_name[$];
  string       t_op[$];
  logic [31:0] t_a[$];
  logic [31:0] t_b[$];
  logic [31:0] t_c[$];
  logic [31:0] t_e[$];
  int          n_tests;
  logic        loaded;
  logic        file_ok;

  integer      seed = 32'h62be4d88;
  string       cur_name;
  int          errors;     // In the current test
  int          pass_cnt;
  int          fail_cnt;
  logic [31:0] cur_a;
  logic [31:0] cur_b;
  logic [31:0] cur_c;
  logic [31:0] cur_e;

  tb_clock_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(10)) u_clk (
    .bp_change (bp_change),
    .reset     (reset)
  );

  gb_debug_top #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) dut (
    .bp_change    (bp_change),
    .reset        (reset),
    .bus_req      (bus_req),
    .pc_fetch     (pc_fetch),
    .btn_step     (btn_step),
    .btn_load     (btn_load),
    .btn_continue (btn_continue),
    .dip_sw       (dip_sw),
    .flash_d      (flash_d),
    .flash_a      (flash_a),
    .flash_adv_b  (flash_adv_b),
    .rd_data      (rd_data),
    .rd_valid     (rd_valid),
    .cpu_halt     (cpu_halt),
    .dbg          (dbg),
    .btn_leds     (btn_leds)
  );

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////
  function automatic gb_data_t reverse_byte(input logic [7:0] v);
    gb_data_t r;
    for (int i = 0; i < 8; i++) begin
      r[i] = v[7 - i];
    end
    return r;
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("MISMATCH %s %s: expected %h, actual %h", cur_name, what, exp, act);
    errors++;
  endtask

  task automatic drive_idle();
    bus_req  <= {16'($random(seed)), 8'($random(seed)), 1'b0, 1'b0};  // No strobes
    pc_fetch <= {16'($random(seed)), 1'b0};
  endtask

  task automatic set_button(input int btn, input logic level);
    case (btn)
      0:       btn_step     <= level;
      1:       btn_load     <= level;
      default: btn_continue <= level;
    endcase
  endtask

  // Whole status word and halt against the model
  task automatic check_model();
    dbg_status_t m_dbg;
    m_dbg = {m_bp, m_state, m_rom, m_ram, m_ram_en};
    if (dbg !== m_dbg) report_mismatch("dbg vs model", m_dbg, dbg);
    if (cpu_halt !== (m_state == HALTED)) begin
      report_mismatch("cpu_halt", 32'(m_state == HALTED), 32'(cpu_halt));
    end
  endtask

  //////////////////////////////////////////////////
  // Operations
  //////////////////////////////////////////////////
  task automatic write_bank(input gb_addr_t addr, input gb_data_t data, input logic [31:0] exp);
    @(posedge bp_change);
    bus_req <= {addr, data, 1'b1, 1'b0};
    @(posedge bp_change);
    drive_idle();
    if (addr < 16'h2000) m_ram_en = (data[3:0] == 4'hA);   // Key value unlocks
    else if (addr < 16'h3000) m_rom[7:0] = data;
    else if (addr < 16'h4000) m_rom[8] = data[0];
    else if (addr < 16'h6000) m_ram = data[3:0];
    @(negedge bp_change);
    if (dbg[13:0] !== exp[13:0]) report_mismatch("bank bits", exp, 32'(dbg[13:0]));
    check_model();
  endtask

  task automatic read_flash(input gb_addr_t addr, input logic [31:0] exp);
    flash_word_t fl_word;
    flash_addr_t m_fa;
    gb_data_t    m_byte;
    int          wait_cnt;
    fl_word  = flash_word_t'($random(seed));
    m_fa     = {(addr[14] ? m_rom : rom_bank_t'(0)), addr[13:1]};
    m_byte   = addr[0] ? fl_word[15:8] : fl_word[7:0];   // High byte for odd addresses
    wait_cnt = 0;
    @(posedge bp_change);
    bus_req <= {addr, 8'($random(seed)), 1'b0, 1'b1};
    flash_d <= fl_word;
    @(negedge bp_change);
    if (flash_a !== exp[21:0]) report_mismatch("flash_a", exp, 32'(flash_a));
    if (flash_a !== m_fa) report_mismatch("flash_a vs model", 32'(m_fa), 32'(flash_a));
    if (flash_adv_b !== 1'b0) report_mismatch("flash_adv_b", 32'(0), 32'(flash_adv_b));
    @(posedge bp_change);
    drive_idle();
    flash_d <= flash_word_t'($random(seed));
    @(negedge bp_change);
    while (rd_valid !== 1'b1 && wait_cnt < 8) begin     // Bounded wait for data
      @(negedge bp_change);
      wait_cnt++;
    end
    if (rd_valid !== 1'b1) begin
      $display("%s: read data never became valid", cur_name);
      errors++;
    end else if (rd_data !== m_byte) begin
      report_mismatch("rd_data", 32'(m_byte), 32'(rd_data));
    end
    @(negedge bp_change);
    if (rd_valid !== 1'b0) begin
      $display("%s: rd_valid stayed high for more than one cycle", cur_name);
      errors++;
    end
    check_model();
  endtask

  task automatic press_button(input int btn, input int hold, input logic [7:0] dip,
                              input logic [31:0] exp);
    logic long_press;
    long_press = (hold > 3 + DEBOUNCE_CYCLES);   // Sync, debounce, output flop
    @(posedge bp_change);
    dip_sw <= dip;
    set_button(btn, 1'b1);
    repeat (hold - 1) @(posedge bp_change);
    @(negedge bp_change);
    if (btn_leds[btn] !== long_press) begin
      report_mismatch("btn_leds while held", 32'(long_press), 32'(btn_leds[btn]));
    end
    @(posedge bp_change);
    set_button(btn, 1'b0);
    repeat (RELEASE_CYCLES) @(posedge bp_change);
    @(negedge bp_change);
    if (btn_leds !== 3'b000) report_mismatch("btn_leds released", 32'(0), 32'(btn_leds));
    if (long_press) begin
      case (btn)
        0: begin
          if (m_state == HALTED) m_state = STEP;
        end
        1: begin
          if (m_load_hi) m_bp[15:8] = reverse_byte(dip);
          else m_bp[7:0] = reverse_byte(dip);
          m_load_hi = ~m_load_hi;
        end
        default: begin
          if (m_state == HALTED) m_state = RESUME;
        end
      endcase
    end
    if (dbg[31:14] !== exp[17:0]) report_mismatch("bp_addr and state", exp, 32'(dbg[31:14]));
    check_model();
  endtask

  task automatic fetch_instr(input gb_addr_t pc, input logic [31:0] exp);
    @(posedge bp_change);
    pc_fetch <= {pc, 1'b1};
    @(posedge bp_change);
    drive_idle();
    case (m_state)
      RUN:     if (pc == m_bp) m_state = HALTED;
      STEP:    m_state = HALTED;    // One instruction only
      RESUME:  m_state = RUN;       // Breakpoint skipped once
      default: ;                    // Fetch dropped while halted
    endcase
    @(negedge bp_change);
    if (dbg.state !== exp[1:0]) report_mismatch("state", exp, 32'(dbg.state));
    check_model();
  endtask

  task automatic check_status(input logic [31:0] exp);
    @(posedge bp_change);
    @(negedge bp_change);
    if (dbg !== exp) report_mismatch("dbg", exp, dbg);
    if (rd_valid !== 1'b0) report_mismatch("rd_valid idle", 32'(0), 32'(rd_valid));
    if (flash_adv_b !== 1'b1) report_mismatch("flash_adv_b idle", 32'(1), 32'(flash_adv_b));
    check_model();
  endtask

  //////////////////////////////////////////////////
  // Test file
  //////////////////////////////////////////////////
  task automatic load_tests();
    int          fd;
    int          code;
    int          ch;
    string       tok;
    string       op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] e;
    fd = $fopen(TESTS_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the tests file %s", TESTS_FILE);
      file_ok = 1'b0;
      return;
    end
    while (!$feof(fd)) begin
      code = $fscanf(fd, "%s", tok);
      if (code != 1) break;
      if (tok.substr(0, 0) == "#") begin
        ch = 0;
        while (ch != 10 && ch != -1) ch = $fgetc(fd);   // Skip to end of line
      end else begin
        code = $fscanf(fd, "%s %h %h %h %h", op, a, b, c, e);
        if (code == 5) begin
          t_name.push_back(tok);
          t_op.push_back(op);
          t_a.push_back(a);
          t_b.push_back(b);
          t_c.push_back(c);
          t_e.push_back(e);
        end else begin
          $display("Tests file line for %s could not be read", tok);
          file_ok = 1'b0;
        end
      end
    end
    $fclose(fd);
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////
  initial begin
    loaded       = 1'b0;
    file_ok      = 1'b1;
    pass_cnt     = 0;
    fail_cnt     = 0;
    btn_step     <= 1'b0;
    btn_load     <= 1'b0;
    btn_continue <= 1'b0;
    dip_sw       <= 8'h00;
    flash_d      <= flash_word_t'($random(seed));
    drive_idle();
    m_rom     = rom_bank_t'(1);   // Values after reset
    m_ram     = '0;
    m_ram_en  = 1'b0;
    m_bp      = '0;
    m_load_hi = 1'b0;
    m_state   = RUN;
    load_tests();
    n_tests = t_name.size();
    loaded  = 1'b1;
    @(negedge reset);
    for (int i = 0; i < n_tests; i++) begin
      cur_name = t_name[i];
      cur_a    = t_a[i];
      cur_b    = t_b[i];
      cur_c    = t_c[i];
      cur_e    = t_e[i];
      errors   = 0;
      if (t_op[i] == "write") write_bank(cur_a[15:0], cur_b[7:0], cur_e);
      else if (t_op[i] == "read") read_flash(cur_a[15:0], cur_e);
      else if (t_op[i] == "press") press_button(int'(cur_a), int'(cur_b), cur_c[7:0], cur_e);
      else if (t_op[i] == "fetch") fetch_instr(cur_a[15:0], cur_e);
      else if (t_op[i] == "check") check_status(cur_e);
      else begin
        $display("%s: unknown operation %s", cur_name, t_op[i]);
        errors++;
      end
      if (errors == 0) begin
        pass_cnt++;
        $display("ok      %s (%s)", cur_name, t_op[i]);
      end else begin
        fail_cnt++;
        $display("failed  %s (%s), %0d error(s)", cur_name, t_op[i], errors);
      end
    end
    $display("Tests run %0d, passed %0d, failed %0d", n_tests, pass_cnt, fail_cnt);
    if (fail_cnt == 0 && n_tests > 0 && file_ok) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // Watchdog budget scales with the number of tests
  initial begin
    wait (loaded === 1'b1);
    #((n_tests + 1) * CYCLES_PER_TEST * CLK_PERIOD_NS);
    $display("Run timed out before all tests completed");
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/gb_debug_tests.txt
# name op a b c expected, all hex. write: addr data; read: addr; press: button hold dip
# expected: write {rom,ram,en}, read flash_a, press {bp_addr,state}, fetch state, check dbg
reset_state check 0 0 0 00000020
ram_en_on write 0a00 0a 0 0021
ram_en_wrong_key write 1fff 0b 0 0020
ram_en_low_nibble write 1234 3a 0 0021
rom_bank_low write 2000 37 0 06e1
rom_bank_bit8 write 3100 01 0 26e1
ram_bank_set write 4000 0c 0 26f9
ram_bank_top write 5abc f5 0 26eb
ignore_6000 write 6000 00 0 26eb
ignore_a000 write a000 ff 0 26eb
rom_bank_zero write 2fff 00 0 200b
rom_bank_105 write 2a00 05 0 20ab
ram_en_off write 0000 00 0 20aa
banks_settled check 0 0 0 000020aa
read_bank0 read 0123 0 0 000091
read_switched read 4567 0 0 20a2b3
read_switched_top read 7ffe 0 0 20bfff
read_bank0_top read 3fff 0 0 001fff
load_low press 1 14 2c 000000d0
load_high press 1 14 48 000048d0
load_glitch press 1 2 ff 000048d0
load_low_again press 1 14 80 00004804
bp_loaded check 0 0 0 120120aa
fetch_miss fetch 1200 0 0 0
fetch_hit fetch 1201 0 0 1
fetch_while_halted fetch 1202 0 0 1
step_press press 0 14 00 00004806
fetch_step fetch 1202 0 0 1
continue_press press 2 14 00 00004807
fetch_resume fetch 1201 0 0 0
fetch_miss_again fetch 1203 0 0 0
fetch_hit_again fetch 1201 0 0 1
halted_status check 0 0 0 120160aa

// File: all.f
logic/gb_bus_pkg.sv
logic/gb_debug_pkg.sv
logic/button_conditioner.sv
logic/mbc5_banking.sv
logic/cart_flash_port.sv
logic/breakpoint_control.sv
logic/gb_debug_top.sv
testbench/tb_clock_gen.sv
testbench/gb_debug_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       := gb_debug_tb
FILELIST  := all.f
OBJ_DIR   := obj_dir
PASS_MSG  := Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
